//--- src.f
+incdir+logic
logic/rf_pkg.sv
logic/tag_pkg.sv
logic/gpr_decode.sv
logic/gpr_sections.sv
logic/tag_tracker.sv
logic/gpr_read_format.sv
logic/gpr_file.sv
test/gpr_file_assertions.sv
test/gpr_file_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the gpr_file testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module gpr_file_tb -o gpr_file_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/gpr_file_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1

//--- test/gpr_file_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module gpr_file_tb;

    import rf_pkg::*;
    import tag_pkg::*;

    logic                  clk;
    logic                  rst_n;
    logic                  wr_en;
    logic [`RF_ADDR_W-1:0] wr_addr;
    acc_size_e             wr_size;
    logic [`RF_DATA_W-1:0] wr_data;
    logic [`RF_ADDR_W-1:0] rd_addr;
    acc_size_e             rd_size;
    logic [`RF_DATA_W-1:0] rd_data;
    logic                  dest_en;
    tag_t                  new_tag;
    logic                  bcast_valid;
    tag_t                  bcast_tag;
    logic                  rd_pend;

    gpr_word_u  model_regs [`RF_NUM_REGS];
    tag_entry_t model_tags [`RF_NUM_REGS][`RF_NUM_SECT];
    int         checks;
    int         errors;

    gpr_file dut0 (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_size(wr_size), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_size(rd_size), .rd_data(rd_data),
        .dest_en(dest_en), .new_tag(new_tag),
        .bcast_valid(bcast_valid), .bcast_tag(bcast_tag),
        .rd_pend(rd_pend)
    );

    always #4 clk = ~clk;

    // sections {e, h, l} touched by an access.
    function automatic sect_mask_t covered(input logic [2:0] addr, input acc_size_e size);
        sect_mask_t m;
        logic [2:0] br;
        m = '0;
        br = {1'b0, addr[1:0]};
        if (size == SIZE_32) begin
            m[addr] = 3'b111;
        end else if (size == SIZE_16) begin
            m[addr] = 3'b011;
        end else if (size == SIZE_8) begin
            m[br] = addr[2] ? 3'b010 : 3'b001; // 4-7 alias the high byte.
        end
        return m;
    endfunction

    function automatic logic [31:0] exp_read(input logic [2:0] addr, input acc_size_e size);
        gpr_word_u  w;
        logic [2:0] br;
        logic [7:0] b;
        br = {1'b0, addr[1:0]};
        w = model_regs[addr];
        b = addr[2] ? model_regs[br].sect.h : model_regs[br].sect.l;
        case (size)
            SIZE_32: return w.word;
            SIZE_16: return {{16{w.word[15]}}, w.word[15:0]};
            SIZE_8:  return {{24{b[7]}}, b};
            default: return '0;
        endcase
    endfunction

    function automatic logic exp_pend(input logic [2:0] addr, input acc_size_e size);
        sect_mask_t m;
        logic       p;
        m = covered(addr, size);
        p = 1'b0;
        for (int r = 0; r < `RF_NUM_REGS; r++) begin
            for (int s = 0; s < `RF_NUM_SECT; s++) begin
                p = p | (m[r][s] & model_tags[r][s].valid);
            end
        end
        return p;
    endfunction

    // called right after the rising edge, while the inputs still hold.
    task automatic apply_model();
        sect_mask_t wm;
        sect_mask_t tm;
        gpr_word_u  d;
        wm = covered(wr_addr, wr_size);
        tm = covered(rd_addr, rd_size);
        d.word = wr_data;
        for (int r = 0; r < `RF_NUM_REGS; r++) begin
            if (wr_en && wm[r][2]) begin
                model_regs[r].sect.e = d.sect.e;
            end
            if (wr_en && wm[r][1]) begin
                model_regs[r].sect.h = wm[r][0] ? d.sect.h : d.sect.l;
            end
            if (wr_en && wm[r][0]) begin
                model_regs[r].sect.l = d.sect.l;
            end
            for (int s = 0; s < `RF_NUM_SECT; s++) begin
                if (dest_en && tm[r][s]) begin
                    model_tags[r][s].valid = 1'b1;
                    model_tags[r][s].tag   = new_tag;
                end else if (bcast_valid && model_tags[r][s].valid &&
                             model_tags[r][s].tag == bcast_tag) begin
                    model_tags[r][s].valid = 1'b0;
                end
            end
        end
    endtask

    task automatic check_outputs();
        logic [31:0] ed;
        logic        ep;
        ed = exp_read(rd_addr, rd_size);
        ep = exp_pend(rd_addr, rd_size);
        checks++;
        if (rd_data !== ed) begin
            errors++;
            $display("[FAIL] rd_data addr=%h size=%h got=%h exp=%h",
                     rd_addr, rd_size, rd_data, ed);
        end
        if (rd_pend !== ep) begin
            errors++;
            $display("[FAIL] rd_pend addr=%h size=%h got=%h exp=%h",
                     rd_addr, rd_size, rd_pend, ep);
        end
    endtask

    task automatic run_cycle(input logic we, input logic [2:0] wa, input acc_size_e ws,
                             input logic [31:0] wd, input logic [2:0] ra, input acc_size_e rs,
                             input logic de, input tag_t nt, input logic bv, input tag_t bt);
        @(negedge clk);
        wr_en       = we;
        wr_addr     = wa;
        wr_size     = ws;
        wr_data     = wd;
        rd_addr     = ra;
        rd_size     = rs;
        dest_en     = de;
        new_tag     = nt;
        bcast_valid = bv;
        bcast_tag   = bt;
        #3;
        check_outputs(); // just before the rising edge.
        @(posedge clk);
        apply_model();
    endtask

    task automatic write_read(input logic we, input logic [2:0] wa, input acc_size_e ws,
                              input logic [31:0] wd, input logic [2:0] ra,
                              input acc_size_e rs);
        run_cycle(we, wa, ws, wd, ra, rs, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic tag_cycle(input logic [2:0] ra, input acc_size_e rs, input logic de,
                             input tag_t nt, input logic bv, input tag_t bt);
        run_cycle(1'b0, '0, SIZE_NONE, '0, ra, rs, de, nt, bv, bt);
    endtask

    task automatic wait_reset_clear();
        int n;
        n = 0;
        while ((rd_pend !== 1'b0 || rd_data !== '0) && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (rd_pend !== 1'b0 || rd_data !== '0) begin
            errors++;
            $display("timeout: outputs did not clear after reset");
        end
    endtask

    task automatic report_test(input string name, input int base);
        $display("test %s done: %0d errors", name, errors - base);
    endtask

    function automatic acc_size_e rand_size(input int hi);
        return acc_size_e'(2'($urandom_range(hi)));
    endfunction

    initial begin
        int          base;
        logic [2:0]  ad;
        logic [31:0] d;
        acc_size_e   sz;
        tag_t        t;
        void'($urandom(32'hfb03_b6b2));
        clk = 1'b0;
        rst_n = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_size = SIZE_NONE;
        wr_data = '0;
        rd_addr = '0;
        rd_size = SIZE_32;
        dest_en = 1'b0;
        new_tag = '0;
        bcast_valid = 1'b0;
        bcast_tag = '0;
        checks = 0;
        errors = 0;
        for (int r = 0; r < `RF_NUM_REGS; r++) begin
            model_regs[r] = '0;
            for (int s = 0; s < `RF_NUM_SECT; s++) begin
                model_tags[r][s] = '0;
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wait_reset_clear();

        base = errors;
        for (int a = 0; a < `RF_NUM_REGS; a++) begin
            for (int s = 0; s < 4; s++) begin
                write_read(1'b0, '0, SIZE_NONE, '0, 3'(a), acc_size_e'(2'(s)));
            end
        end
        repeat (40) begin
            ad = 3'($urandom());
            d = $urandom();
            write_read(1'b1, ad, SIZE_32, d, ad, SIZE_32);
            write_read(1'b0, '0, SIZE_NONE, '0, ad, SIZE_32);
        end
        report_test("full_width", base);

        base = errors;
        repeat (60) begin
            ad = 3'($urandom());
            sz = $urandom_range(1) ? SIZE_16 : SIZE_8;
            d = $urandom();
            write_read(1'b1, ad, sz, d, ad, SIZE_32);
            write_read(1'b0, '0, SIZE_NONE, '0, (sz == SIZE_8) ? {1'b0, ad[1:0]} : ad, SIZE_32);
        end
        report_test("partial", base);

        base = errors;
        repeat (30) begin
            ad = {1'b1, 2'($urandom())};
            d = $urandom();
            write_read(1'b1, ad, SIZE_8, d, ad, SIZE_8);
            write_read(1'b0, '0, SIZE_NONE, '0, ad, SIZE_8);
            write_read(1'b0, '0, SIZE_NONE, '0, {1'b0, ad[1:0]}, SIZE_32);
        end
        report_test("high_byte", base);

        base = errors;
        for (int a = 0; a < `RF_NUM_REGS; a++) begin
            write_read(1'b1, 3'(a), SIZE_32, $urandom(), 3'(a), SIZE_16);
        end
        repeat (60) begin
            write_read(1'b0, '0, SIZE_NONE, '0, 3'($urandom()), rand_size(1));
        end
        report_test("sign_extend", base);

        base = errors;
        repeat (20) begin
            ad = 3'($urandom());
            sz = rand_size(2);
            t = 7'($urandom());
            tag_cycle(ad, sz, 1'b1, t, 1'b0, '0);
            tag_cycle(ad, sz, 1'b0, '0, 1'b1, t ^ 7'h55); // must not clear.
            tag_cycle(ad, sz, 1'b0, '0, 1'b1, t);
            tag_cycle(ad, sz, 1'b0, '0, 1'b0, '0);
        end
        report_test("tag_set_clear", base);

        base = errors;
        repeat (10) begin
            ad = 3'($urandom());
            sz = rand_size(2);
            t = 7'($urandom());
            tag_cycle(ad, sz, 1'b1, t, 1'b0, '0);
            tag_cycle(ad, sz, 1'b1, t, 1'b1, t);
            tag_cycle(ad, sz, 1'b0, '0, 1'b1, t);
            tag_cycle(ad, sz, 1'b0, '0, 1'b0, '0);
        end
        report_test("set_beats_clear", base);

        base = errors;
        repeat (400) begin
            // few tag values so broadcasts hit often.
            run_cycle(1'($urandom_range(1)), 3'($urandom()), rand_size(3), $urandom(),
                      3'($urandom()), rand_size(3), 1'($urandom_range(1)),
                      7'($urandom_range(7)), 1'($urandom_range(1)), 7'($urandom_range(7)));
        end
        report_test("random_mix", base);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/gpr_file_assertions.sv
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module gpr_file_assertions (
    input wire                    clk,
    input wire                    rst_n,
    input wire [`RF_ADDR_W-1:0]   rd_addr,
    input wire rf_pkg::acc_size_e rd_size,
    input wire [`RF_DATA_W-1:0]   rd_data,
    input wire                    dest_en,
    input wire                    rd_pend
);

    import rf_pkg::*;

    a_sign_8: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_size == SIZE_8) |-> (rd_data[31:8] == {24{rd_data[7]}}))
        else $error("rd_data upper bits differ from sign bit on 8-bit read");

    a_sign_16: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_size == SIZE_16) |-> (rd_data[31:16] == {16{rd_data[15]}}))
        else $error("rd_data upper bits differ from sign bit on 16-bit read");

    a_pend_after_reset: assert property (@(posedge clk) !rst_n |=> !rd_pend)
        else $error("rd_pend high in the cycle after reset");

    // a tag set shows up on the same read one cycle later.
    a_pend_after_set: assert property (@(posedge clk) disable iff (!rst_n)
        (dest_en && rd_size != SIZE_NONE) |=>
            (rd_pend || rd_addr != $past(rd_addr) || rd_size != $past(rd_size)))
        else $error("rd_pend low on the read that follows a tag set");

endmodule

bind gpr_file gpr_file_assertions asrt0 (
    .clk(clk), .rst_n(rst_n),
    .rd_addr(rd_addr), .rd_size(rd_size), .rd_data(rd_data),
    .dest_en(dest_en), .rd_pend(rd_pend)
);

`default_nettype wire

//--- logic/gpr_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module gpr_file (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    wr_en,
    input  wire [`RF_ADDR_W-1:0]   wr_addr,
    input  wire rf_pkg::acc_size_e wr_size,
    input  wire [`RF_DATA_W-1:0]   wr_data,
    input  wire [`RF_ADDR_W-1:0]   rd_addr,
    input  wire rf_pkg::acc_size_e rd_size,
    output logic [`RF_DATA_W-1:0]  rd_data,
    input  wire                    dest_en,
    input  wire tag_pkg::tag_t     new_tag,
    input  wire                    bcast_valid,
    input  wire tag_pkg::tag_t     bcast_tag,
    output logic                   rd_pend
);

    import rf_pkg::*;

    sect_mask_t                   wr_mask;
    sect_mask_t                   rd_mask;
    gpr_word_u [`RF_NUM_REGS-1:0] regs;

    gpr_decode dec_wr (.addr(wr_addr), .size(wr_size), .mask(wr_mask));

    gpr_decode dec_rd (.addr(rd_addr), .size(rd_size), .mask(rd_mask));

    gpr_sections sect0 (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_mask(wr_mask), .wr_data(wr_data),
        .regs(regs)
    );

    // tags are set through the read address, as for a destination operand.
    tag_tracker tag0 (
        .clk(clk), .rst_n(rst_n),
        .dest_en(dest_en), .rd_mask(rd_mask), .new_tag(new_tag),
        .bcast_valid(bcast_valid), .bcast_tag(bcast_tag),
        .rd_pend(rd_pend)
    );

    gpr_read_format fmt0 (
        .rd_addr(rd_addr), .rd_size(rd_size),
        .regs(regs), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

//--- logic/gpr_read_format.sv
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module gpr_read_format (
    input  wire [`RF_ADDR_W-1:0]                rd_addr,
    input  wire rf_pkg::acc_size_e              rd_size,
    input  wire rf_pkg::gpr_word_u [`RF_NUM_REGS-1:0] regs,
    output logic [`RF_DATA_W-1:0]               rd_data
);

    import rf_pkg::*;

    gpr_word_u             word;
    gpr_word_u             byte_word;
    logic [`RF_ADDR_W-1:0] byte_reg;
    logic [7:0]            byte_val;

    assign byte_reg  = {1'b0, rd_addr[`RF_ADDR_W-2:0]};
    assign word      = regs[rd_addr];
    assign byte_word = regs[byte_reg];

    // same aliasing rule as the decoder.
    always_comb begin
        if (rd_addr[`RF_ADDR_W-1]) begin
            byte_val = byte_word.sect.h;
        end else begin
            byte_val = byte_word.sect.l;
        end
    end

    always_comb begin
        case (rd_size)
            SIZE_32: begin
                rd_data = word.word;
            end
            SIZE_16: begin
                rd_data = {{(`RF_DATA_W-16){word.sect.h[7]}}, word.sect.h, word.sect.l};
            end
            SIZE_8: begin
                rd_data = {{(`RF_DATA_W-8){byte_val[7]}}, byte_val};
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/tag_tracker.sv
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module tag_tracker (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     dest_en,
    input  wire rf_pkg::sect_mask_t rd_mask,
    input  wire tag_pkg::tag_t      new_tag,
    input  wire                     bcast_valid,
    input  wire tag_pkg::tag_t      bcast_tag,
    output logic                    rd_pend
);

    import tag_pkg::*;

    tag_entry_t [`RF_NUM_REGS-1:0][`RF_NUM_SECT-1:0] entries;
    logic       [`RF_NUM_REGS-1:0][`RF_NUM_SECT-1:0] set_hit;
    logic       [`RF_NUM_REGS-1:0][`RF_NUM_SECT-1:0] clr_hit;

    always_comb begin
        for (int r = 0; r < `RF_NUM_REGS; r++) begin
            for (int s = 0; s < `RF_NUM_SECT; s++) begin
                set_hit[r][s] = dest_en & rd_mask[r][s];
                clr_hit[r][s] = bcast_valid & entries[r][s].valid &
                                (entries[r][s].tag == bcast_tag);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entries <= '0;
        end else begin
            for (int r = 0; r < `RF_NUM_REGS; r++) begin
                for (int s = 0; s < `RF_NUM_SECT; s++) begin
                    if (set_hit[r][s]) begin
                        entries[r][s].valid <= 1'b1; // set wins over a same-cycle clear.
                        entries[r][s].tag   <= new_tag;
                    end else if (clr_hit[r][s]) begin
                        entries[r][s].valid <= 1'b0;
                    end
                end
            end
        end
    end

    // pending if any section the read covers still waits on a producer.
    always_comb begin
        rd_pend = 1'b0;
        for (int r = 0; r < `RF_NUM_REGS; r++) begin
            for (int s = 0; s < `RF_NUM_SECT; s++) begin
                rd_pend = rd_pend | (rd_mask[r][s] & entries[r][s].valid);
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/gpr_sections.sv
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module gpr_sections (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       wr_en,
    input  wire rf_pkg::sect_mask_t   wr_mask,
    input  wire [`RF_DATA_W-1:0]      wr_data,
    output rf_pkg::gpr_word_u [`RF_NUM_REGS-1:0] regs
);

    import rf_pkg::*;

    gpr_word_u                   wd;
    logic [`RF_NUM_REGS-1:0][7:0] h_in;

    assign wd.word = wr_data;

    // a byte write to h carries its value in the low byte of the bus.
    always_comb begin
        for (int r = 0; r < `RF_NUM_REGS; r++) begin
            if (wr_mask[r][SECT_L]) begin
                h_in[r] = wd.sect.h; // 16/32-bit write.
            end else begin
                h_in[r] = wd.sect.l;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (wr_en) begin
            for (int r = 0; r < `RF_NUM_REGS; r++) begin
                if (wr_mask[r][SECT_E]) begin
                    regs[r].sect.e <= wd.sect.e;
                end
                if (wr_mask[r][SECT_H]) begin
                    regs[r].sect.h <= h_in[r];
                end
                if (wr_mask[r][SECT_L]) begin
                    regs[r].sect.l <= wd.sect.l;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/gpr_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module gpr_decode (
    input  wire [`RF_ADDR_W-1:0] addr,
    input  wire rf_pkg::acc_size_e size,
    output rf_pkg::sect_mask_t   mask
);

    import rf_pkg::*;

    logic                  high_byte;
    logic [`RF_ADDR_W-1:0] byte_reg;

    // addresses 4-7 at byte size alias the h byte of registers 0-3.
    assign high_byte = addr[`RF_ADDR_W-1];
    assign byte_reg  = {1'b0, addr[`RF_ADDR_W-2:0]};

    always_comb begin
        mask = '0;
        case (size)
            SIZE_32: begin
                mask[addr][SECT_E] = 1'b1;
                mask[addr][SECT_H] = 1'b1;
                mask[addr][SECT_L] = 1'b1;
            end
            SIZE_16: begin
                mask[addr][SECT_H] = 1'b1;
                mask[addr][SECT_L] = 1'b1;
            end
            SIZE_8: begin
                if (high_byte) begin
                    mask[byte_reg][SECT_H] = 1'b1;
                end else begin
                    mask[byte_reg][SECT_L] = 1'b1;
                end
            end
            default: begin
                mask = '0; // no access.
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/tag_pkg.sv
`default_nettype none

`include "rf_macros.svh"

package tag_pkg;

    typedef logic [`RF_TAG_W-1:0] tag_t;

    // one pending-producer slot per register section.
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

endpackage

`default_nettype wire

//--- logic/rf_pkg.sv
`default_nettype none

`include "rf_macros.svh"

package rf_pkg;

    typedef enum logic [1:0] {
        SIZE_8    = 2'b00,
        SIZE_16   = 2'b01,
        SIZE_32   = 2'b10,
        SIZE_NONE = 2'b11 // no access.
    } acc_size_e;

    // bit positions of the sections inside one register's mask.
    localparam int SECT_L = 0;
    localparam int SECT_H = 1;
    localparam int SECT_E = 2;

    typedef logic [`RF_NUM_REGS-1:0][`RF_NUM_SECT-1:0] sect_mask_t;

    typedef struct packed {
        logic [15:0] e;
        logic [7:0]  h;
        logic [7:0]  l;
    } gpr_sect_t;

    typedef union packed {
        logic [`RF_DATA_W-1:0] word;
        gpr_sect_t             sect;
    } gpr_word_u;

endpackage

`default_nettype wire

//--- logic/rf_macros.svh
`ifndef RF_MACROS_SVH
`define RF_MACROS_SVH

// register file geometry.
`define RF_NUM_REGS 8
`define RF_ADDR_W   3
`define RF_DATA_W   32

// producer tag width.
`define RF_TAG_W    7

// sections per register: e, h and l.
`define RF_NUM_SECT 3

`endif
